// File: src/soc_xbar_pkg.sv
package soc_xbar_pkg;

  // Initiators in order cluster 0, cluster 1, ext, debug
  localparam int unsigned n_init = 4;

  // Targets in order cluster 0, cluster 1, L2, ext, debug
  localparam int unsigned n_tgt = 5;

  localparam int unsigned tgt_cl0 = 0;
  localparam int unsigned tgt_cl1 = 1;
  localparam int unsigned tgt_l2  = 2;
  localparam int unsigned tgt_ext = 3;
  localparam int unsigned tgt_dbg = 4;

  localparam int unsigned addr_w = 32;  // [bit]
  localparam int unsigned data_w = 32;  // [bit]

  localparam int unsigned init_id_w  = 2;                      // ID as sent by an initiator
  localparam int unsigned init_idx_w = 2;                      // Which initiator
  localparam int unsigned tgt_id_w   = init_idx_w + init_id_w; // Tag seen by targets

  // Request queue sizing
  localparam int unsigned queue_depth = 4;
  localparam int unsigned queue_ptr_w = $clog2(queue_depth);
  localparam int unsigned queue_cnt_w = $clog2(queue_depth + 1);  // Holds 0 up to full

  // Cluster slots, one every stride
  localparam logic [addr_w-1:0] cl_base   = 32'h1000_0000;
  localparam logic [addr_w-1:0] cl_stride = 32'h0040_0000;
  localparam logic [addr_w-1:0] cl_size   = 32'h0030_0000;

  // Everything below cluster 0 goes external
  localparam logic [addr_w-1:0] ext_lo_end = 32'h0FFF_FFFF;

  // Peripheral space in 0x1A.., routed external apart from the debug window
  localparam logic [addr_w-1:0] ext_mid_start = 32'h1A00_0000;
  localparam logic [addr_w-1:0] ext_mid_end   = 32'h1AFF_FFFF;

  localparam logic [addr_w-1:0] dbg_base = 32'h1A11_0000;
  localparam logic [addr_w-1:0] dbg_size = 32'h0000_1000;

  localparam logic [addr_w-1:0] l2_base = 32'h1C00_0000;
  localparam logic [addr_w-1:0] l2_size = 32'h0010_0000;

  // Everything above L2 goes external again
  localparam logic [addr_w-1:0] ext_hi_start = l2_base + l2_size;

  // Widened transaction tag
  // Targets only see raw and echo it back unchanged
  typedef union packed {
    logic [tgt_id_w-1:0] raw;
    struct packed {
      logic [init_idx_w-1:0] init_idx;  // Upper bits
      logic [init_id_w-1:0]  init_id;   // Lower bits
    } fld;
  } xbar_id_u;

endpackage

// File: src/bus_req_if.sv
`timescale 1ns/10ps

// One request word, either a queue head or the routed target request
interface bus_req_if #(
  parameter int unsigned id_w = soc_xbar_pkg::init_id_w
);
  import soc_xbar_pkg::*;

  logic              valid;  // Strobe, or head present on the queue side
  logic              we;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic [id_w-1:0]   id;     // Init ID at the queues, widened tag at the targets

  modport initiator (
    output valid,
    output we,
    output addr,
    output wdata,
    output id
  );

  modport receiver (
    input valid,
    input we,
    input addr,
    input wdata,
    input id
  );

endinterface

// File: src/req_queue.sv
`timescale 1ns/10ps

module req_queue (
  input  logic                                clk_i,
  input  logic                                rst_n,
  input  logic                                push,
  input  logic                                push_we,
  input  logic [soc_xbar_pkg::addr_w-1:0]     push_addr,
  input  logic [soc_xbar_pkg::data_w-1:0]     push_wdata,
  input  logic [soc_xbar_pkg::init_id_w-1:0]  push_id,
  input  logic                                pop,
  bus_req_if.initiator                        head
);
  import soc_xbar_pkg::*;

  // Entry storage
  logic                 we_mem    [queue_depth];
  logic [addr_w-1:0]    addr_mem  [queue_depth];
  logic [data_w-1:0]    wdata_mem [queue_depth];
  logic [init_id_w-1:0] id_mem    [queue_depth];

  logic [queue_ptr_w-1:0] rd_ptr;
  logic [queue_ptr_w-1:0] wr_ptr;
  logic [queue_cnt_w-1:0] count;

  logic empty;
  logic full;
  logic do_push;
  logic do_pop;

  assign empty = (count == '0);
  assign full  = (count == queue_cnt_w'(queue_depth));

  assign do_pop  = pop & ~empty;
  assign do_push = push & (~full | do_pop);  // A full queue still takes a push while draining

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, pointers wrap
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      we_mem[wr_ptr]    <= push_we;
      addr_mem[wr_ptr]  <= push_addr;
      wdata_mem[wr_ptr] <= push_wdata;
      id_mem[wr_ptr]    <= push_id;
    end
  end

  // Oldest entry
  assign head.valid = ~empty;
  assign head.we    = we_mem[rd_ptr];
  assign head.addr  = addr_mem[rd_ptr];
  assign head.wdata = wdata_mem[rd_ptr];
  assign head.id    = id_mem[rd_ptr];

  // Initiator must respect the outstanding limit, the router cannot stall it
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    push && full |-> pop
  ) else $error("req_queue: push into full queue");

endmodule

// File: src/req_router.sv
`timescale 1ns/10ps

module req_router (
  input  logic                              clk_i,
  input  logic                              rst_n,
  bus_req_if.receiver                       heads [soc_xbar_pkg::n_init],
  output logic [soc_xbar_pkg::n_init-1:0]   pop,
  bus_req_if.initiator                      tgt,
  output logic [soc_xbar_pkg::n_tgt-1:0]    tgt_sel,
  output logic                              dec_err,
  output soc_xbar_pkg::xbar_id_u            dec_err_id
);
  import soc_xbar_pkg::*;

  logic [n_init-1:0]                head_valid;
  logic [n_init-1:0]                head_we;
  logic [n_init-1:0][addr_w-1:0]    head_addr;
  logic [n_init-1:0][data_w-1:0]    head_wdata;
  logic [n_init-1:0][init_id_w-1:0] head_id;

  logic [init_idx_w-1:0] rr_ptr;    // Last granted initiator
  logic [init_idx_w-1:0] gnt_idx;
  logic                  gnt_valid;
  logic [n_tgt-1:0]      sel_d;
  xbar_id_u              gnt_id;

  logic              we_q;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  xbar_id_u          id_q;

  // Flatten the head array so it can be indexed at run time
  for (genvar i = 0; i < n_init; i++) begin : gen_heads
    assign head_valid[i] = heads[i].valid;
    assign head_we[i]    = heads[i].we;
    assign head_addr[i]  = heads[i].addr;
    assign head_wdata[i] = heads[i].wdata;
    assign head_id[i]    = heads[i].id;
  end

  // One-hot target for an address, zero on a hole in the map
  function automatic logic [n_tgt-1:0] decode_sel(input logic [addr_w-1:0] addr);
    logic [n_tgt-1:0] sel;
    sel = '0;
    if (addr <= ext_lo_end) sel[tgt_ext] = 1'b1;
    else if (addr >= cl_base && addr < cl_base + cl_size) sel[tgt_cl0] = 1'b1;
    else if (addr >= cl_base + cl_stride && addr < cl_base + cl_stride + cl_size)
      sel[tgt_cl1] = 1'b1;
    else if (addr >= dbg_base && addr < dbg_base + dbg_size) sel[tgt_dbg] = 1'b1;
    else if (addr >= ext_mid_start && addr <= ext_mid_end) sel[tgt_ext] = 1'b1;
    else if (addr >= l2_base && addr < l2_base + l2_size) sel[tgt_l2] = 1'b1;
    else if (addr >= ext_hi_start) sel[tgt_ext] = 1'b1;
    return sel;
  endfunction

  // Round robin, search starts right after the last winner
  always_comb begin
    logic [init_idx_w-1:0] cand;
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    for (int k = 1; k <= n_init; k++) begin
      cand = rr_ptr + init_idx_w'(k);  // Index wraps with n_init a power of two
      if (!gnt_valid && head_valid[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  always_comb begin
    pop = '0;
    if (gnt_valid) pop[gnt_idx] = 1'b1;
  end

  assign sel_d = decode_sel(head_addr[gnt_idx]);

  assign gnt_id.fld.init_idx = gnt_idx;
  assign gnt_id.fld.init_id  = head_id[gnt_idx];

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rr_ptr  <= init_idx_w'(n_init - 1);  // Initiator 0 wins first
      tgt_sel <= '0;
      dec_err <= 1'b0;
    end else begin
      if (gnt_valid) rr_ptr <= gnt_idx;
      tgt_sel <= gnt_valid ? sel_d : '0;
      dec_err <= gnt_valid && (sel_d == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      we_q    <= head_we[gnt_idx];
      addr_q  <= head_addr[gnt_idx];
      wdata_q <= head_wdata[gnt_idx];
      id_q    <= gnt_id;
    end
  end

  assign tgt.valid  = |tgt_sel;
  assign tgt.we     = we_q;
  assign tgt.addr   = addr_q;
  assign tgt.wdata  = wdata_q;
  assign tgt.id     = id_q.raw;
  assign dec_err_id = id_q;  // Same tag register as the target side

  a_sel_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    $onehot0(tgt_sel)
  ) else $error("req_router: more than one target selected");

endmodule

// File: src/rsp_router.sv
`timescale 1ns/10ps

module rsp_router (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n,
  input  logic [soc_xbar_pkg::n_tgt-1:0]                         tgt_rsp,
  input  logic [soc_xbar_pkg::n_tgt-1:0][soc_xbar_pkg::data_w-1:0]   tgt_rdata,
  input  logic [soc_xbar_pkg::n_tgt-1:0][soc_xbar_pkg::tgt_id_w-1:0] tgt_rsp_id,
  input  logic                                                   dec_err,
  input  soc_xbar_pkg::xbar_id_u                                 dec_err_id,
  output logic [soc_xbar_pkg::n_init-1:0]                        init_rsp,
  output logic [soc_xbar_pkg::n_init-1:0][soc_xbar_pkg::data_w-1:0]    init_rdata,
  output logic [soc_xbar_pkg::n_init-1:0][soc_xbar_pkg::init_id_w-1:0] init_rsp_id,
  output logic [soc_xbar_pkg::n_init-1:0]                        init_rsp_err
);
  import soc_xbar_pkg::*;

  // Error held one cycle so it lines up with a target answer
  logic     err_q;
  xbar_id_u err_id_q;

  logic              sel_valid;
  logic              sel_err;
  logic [data_w-1:0] sel_data;
  xbar_id_u          sel_id;

  always_ff @(posedge clk_i) begin
    if (!rst_n) err_q <= 1'b0;
    else        err_q <= dec_err;
  end

  always_ff @(posedge clk_i) begin
    if (dec_err) err_id_q <= dec_err_id;
  end

  // At most one source is active per cycle
  always_comb begin
    sel_valid = 1'b0;
    sel_err   = 1'b0;
    sel_data  = '0;
    sel_id    = '0;
    for (int t = 0; t < n_tgt; t++) begin
      if (tgt_rsp[t]) begin
        sel_valid  = 1'b1;
        sel_data   = tgt_rdata[t];
        sel_id.raw = tgt_rsp_id[t];
      end
    end
    if (err_q) begin
      sel_valid = 1'b1;
      sel_err   = 1'b1;
      sel_data  = '0;      // Errors return no data
      sel_id    = err_id_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      init_rsp <= '0;
    end else begin
      init_rsp <= '0;
      if (sel_valid) init_rsp[sel_id.fld.init_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_valid) begin
      init_rdata[sel_id.fld.init_idx]   <= sel_data;
      init_rsp_id[sel_id.fld.init_idx]  <= sel_id.fld.init_id;  // Original ID, index stripped
      init_rsp_err[sel_id.fld.init_idx] <= sel_err;
    end
  end

  // Targets answer one cycle after their strobe, so responses never overlap
  a_one_rsp: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    $onehot0(tgt_rsp)
  ) else $error("rsp_router: several target responses in one cycle");

  a_no_err_clash: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    err_q |-> (tgt_rsp == '0)
  ) else $error("rsp_router: target response collides with decode error");

endmodule

// File: src/soc_xbar.sv
`timescale 1ns/10ps

module soc_xbar (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n,
  // Initiator side
  input  logic [soc_xbar_pkg::n_init-1:0]                          init_req,
  input  logic [soc_xbar_pkg::n_init-1:0]                          init_we,
  input  logic [soc_xbar_pkg::n_init-1:0][soc_xbar_pkg::addr_w-1:0]    init_addr,
  input  logic [soc_xbar_pkg::n_init-1:0][soc_xbar_pkg::data_w-1:0]    init_wdata,
  input  logic [soc_xbar_pkg::n_init-1:0][soc_xbar_pkg::init_id_w-1:0] init_id,
  output logic [soc_xbar_pkg::n_init-1:0]                          init_rsp,
  output logic [soc_xbar_pkg::n_init-1:0][soc_xbar_pkg::data_w-1:0]    init_rdata,
  output logic [soc_xbar_pkg::n_init-1:0][soc_xbar_pkg::init_id_w-1:0] init_rsp_id,
  output logic [soc_xbar_pkg::n_init-1:0]                          init_rsp_err,
  // Target side, fields shared and qualified by the strobe vector
  output logic [soc_xbar_pkg::n_tgt-1:0]                           tgt_req,
  output logic                                                     tgt_we,
  output logic [soc_xbar_pkg::addr_w-1:0]                          tgt_addr,
  output logic [soc_xbar_pkg::data_w-1:0]                          tgt_wdata,
  output logic [soc_xbar_pkg::tgt_id_w-1:0]                        tgt_id,
  input  logic [soc_xbar_pkg::n_tgt-1:0]                           tgt_rsp,
  input  logic [soc_xbar_pkg::n_tgt-1:0][soc_xbar_pkg::data_w-1:0]     tgt_rdata,
  input  logic [soc_xbar_pkg::n_tgt-1:0][soc_xbar_pkg::tgt_id_w-1:0]   tgt_rsp_id
);
  import soc_xbar_pkg::*;

  logic [n_init-1:0] pop;
  logic              dec_err;
  xbar_id_u          dec_err_id;

  bus_req_if #(.id_w(init_id_w)) head_if [n_init] ();
  bus_req_if #(.id_w(tgt_id_w))  tgt_if ();

  for (genvar i = 0; i < n_init; i++) begin : gen_queues
    req_queue i_req_queue (
      .clk_i      (clk_i),
      .rst_n      (rst_n),
      .push       (init_req[i]),
      .push_we    (init_we[i]),
      .push_addr  (init_addr[i]),
      .push_wdata (init_wdata[i]),
      .push_id    (init_id[i]),
      .pop        (pop[i]),
      .head       (head_if[i])
    );
  end

  req_router i_req_router (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .heads      (head_if),
    .pop        (pop),
    .tgt        (tgt_if),
    .tgt_sel    (tgt_req),
    .dec_err    (dec_err),
    .dec_err_id (dec_err_id)
  );

  assign tgt_we    = tgt_if.we;
  assign tgt_addr  = tgt_if.addr;
  assign tgt_wdata = tgt_if.wdata;
  assign tgt_id    = tgt_if.id;

  rsp_router i_rsp_router (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .tgt_rsp      (tgt_rsp),
    .tgt_rdata    (tgt_rdata),
    .tgt_rsp_id   (tgt_rsp_id),
    .dec_err      (dec_err),
    .dec_err_id   (dec_err_id),
    .init_rsp     (init_rsp),
    .init_rdata   (init_rdata),
    .init_rsp_id  (init_rsp_id),
    .init_rsp_err (init_rsp_err)
  );

endmodule

// File: verif/soc_xbar_tb.sv
`timescale 1ns/10ps

module soc_xbar_tb;
  import soc_xbar_pkg::*;

  localparam int clk_period = 10;
  // Requests per test: decode, write/read, errors, round robin, mixed
  localparam int test_len = 10 + 24 + 3 + 8 + 16;

  logic                                clk_i;
  logic                                rst_n;
  logic [n_init-1:0]                   init_req;
  logic [n_init-1:0]                   init_we;
  logic [n_init-1:0][addr_w-1:0]       init_addr;
  logic [n_init-1:0][data_w-1:0]       init_wdata;
  logic [n_init-1:0][init_id_w-1:0]    init_id;
  logic [n_init-1:0]                   init_rsp;
  logic [n_init-1:0][data_w-1:0]       init_rdata;
  logic [n_init-1:0][init_id_w-1:0]    init_rsp_id;
  logic [n_init-1:0]                   init_rsp_err;
  logic [n_tgt-1:0]                    tgt_req;
  logic                                tgt_we;
  logic [addr_w-1:0]                   tgt_addr;
  logic [data_w-1:0]                   tgt_wdata;
  logic [tgt_id_w-1:0]                 tgt_id;
  logic [n_tgt-1:0]                    tgt_rsp;
  logic [n_tgt-1:0][data_w-1:0]        tgt_rdata;
  logic [n_tgt-1:0][tgt_id_w-1:0]      tgt_rsp_id;

  // Requests staged for the next edge
  logic [n_init-1:0]                   pend_req;
  logic [n_init-1:0]                   pend_we;
  logic [n_init-1:0][addr_w-1:0]       pend_addr;
  logic [n_init-1:0][data_w-1:0]       pend_wdata;
  logic [n_init-1:0][init_id_w-1:0]    pend_id;

  logic [31:0] tmem   [n_tgt][64];  // Target memories, word index addr[7:2]
  logic [31:0] sb_mem [n_tgt][64];  // Scoreboard copy
  logic [34:0] got_q  [n_init][$];  // {err, id, data}
  logic [34:0] exp_q  [n_init][$];
  logic [73:0] tlog_q [$];          // {tgt_req, tgt_id, tgt_we, tgt_addr, tgt_wdata} per strobe
  logic [31:0] lcg_state;
  int          chk_cnt;
  int          err_cnt;

  soc_xbar dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // Targets answer one cycle after their strobe
  always @(posedge clk_i) begin
    for (int t = 0; t < n_tgt; t++) begin
      tgt_rsp[t] <= tgt_req[t];
      if (tgt_req[t]) begin
        tgt_rsp_id[t] <= tgt_id;
        if (tgt_we) begin
          tmem[t][tgt_addr[7:2]] <= tgt_wdata;
          tgt_rdata[t]           <= '0;
        end else begin
          tgt_rdata[t] <= tmem[t][tgt_addr[7:2]];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    for (int i = 0; i < n_init; i++)
      if (init_rsp[i]) got_q[i].push_back({init_rsp_err[i], init_rsp_id[i], init_rdata[i]});
    if (|tgt_req) tlog_q.push_back({tgt_req, tgt_id, tgt_we, tgt_addr, tgt_wdata});
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Target index from the region map, -1 for a hole
  function automatic int exp_target(input logic [31:0] a);
    if (a >= dbg_base && a < dbg_base + dbg_size) return tgt_dbg;  // Wins over ext_mid
    if (a <= ext_lo_end) return tgt_ext;
    for (int i = 0; i < 2; i++)
      if (a >= cl_base + i * cl_stride && a < cl_base + i * cl_stride + cl_size) return i;
    if (a >= ext_mid_start && a <= ext_mid_end) return tgt_ext;
    if (a >= l2_base && a < l2_base + l2_size) return tgt_l2;
    if (a >= ext_hi_start) return tgt_ext;
    return -1;
  endfunction

  // Word w of initiator i's slice inside target t
  function automatic logic [31:0] slot_addr(input int t, input int i, input int w);
    logic [31:0] base;
    case (t)
      tgt_cl0: base = cl_base;
      tgt_cl1: base = cl_base + cl_stride;
      tgt_l2:  base = l2_base;
      tgt_dbg: base = dbg_base;
      default: base = 32'h3000_0000;
    endcase
    return base + 32'((i * 16 + w % 16) * 4);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Stage a request and predict its response
  task automatic send(input int i, input logic we, input logic [31:0] addr,
                      input logic [31:0] wdata, input logic [1:0] id);
    int         t;
    logic [5:0] w;
    t = exp_target(addr);
    w = addr[7:2];
    pend_req[i]   = 1'b1;
    pend_we[i]    = we;
    pend_addr[i]  = addr;
    pend_wdata[i] = wdata;
    pend_id[i]    = id;
    if (t < 0) begin
      exp_q[i].push_back({1'b1, id, 32'h0});
    end else if (we) begin
      sb_mem[t][w] = wdata;
      exp_q[i].push_back({1'b0, id, 32'h0});
    end else begin
      exp_q[i].push_back({1'b0, id, sb_mem[t][w]});
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    init_req   <= pend_req;
    init_we    <= pend_we;
    init_addr  <= pend_addr;
    init_wdata <= pend_wdata;
    init_id    <= pend_id;
    pend_req = '0;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n <= 1'b0;
    repeat (5) step();
    rst_n <= 1'b1;
  endtask

  task automatic check_responses();
    logic [34:0] got;
    logic [34:0] exp;
    for (int i = 0; i < n_init; i++) begin
      if (got_q[i].size() != exp_q[i].size()) begin
        err_cnt++;
        $display("Initiator %0d got %0d responses, expected %0d",
                 i, got_q[i].size(), exp_q[i].size());
      end
      while (got_q[i].size() > 0 && exp_q[i].size() > 0) begin
        got = got_q[i].pop_front();
        exp = exp_q[i].pop_front();
        check_val($sformatf("init_rdata[%0d]", i), got[31:0], exp[31:0]);
        check_val($sformatf("init_rsp_id[%0d]", i), got[33:32], exp[33:32]);
        check_val($sformatf("init_rsp_err[%0d]", i), got[34], exp[34]);
      end
      got_q[i].delete();
      exp_q[i].delete();
    end
  endtask

  // Run until every predicted response is back, then compare
  task automatic wait_idle();
    int cycles;
    bit busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy && cycles < 200) begin
      step();
      cycles++;
      busy = 1'b0;
      for (int i = 0; i < n_init; i++)
        if (got_q[i].size() < exp_q[i].size()) busy = 1'b1;
    end
    if (busy) begin
      err_cnt++;
      $display("Responses still missing after %0d cycles", cycles);
    end
    repeat (2) step();  // Catch stray responses
    check_responses();
  endtask

  // Single access with its target strobe checked
  task automatic access_one(input int i, input logic we, input logic [31:0] addr,
                            input logic [1:0] id);
    int          t;
    logic [31:0] wdata;
    logic [73:0] ent;
    t     = exp_target(addr);
    wdata = next_rand();
    tlog_q.delete();
    send(i, we, addr, wdata, id);
    wait_idle();
    if (t < 0 && tlog_q.size() != 0) begin
      err_cnt++;
      $display("Hole address 0x%0h strobed a target", addr);
    end else if (t >= 0 && tlog_q.size() != 1) begin
      err_cnt++;
      $display("Address 0x%0h gave %0d target strobes", addr, tlog_q.size());
    end else if (t >= 0) begin
      ent = tlog_q[0];
      check_val("tgt_req", ent[73:69], 32'd1 << t);
      check_val("tgt_id", ent[68:65], {i[1:0], id});
      check_val("tgt_we", ent[64], we);
      check_val("tgt_addr", ent[63:32], addr);
      if (we) check_val("tgt_wdata", ent[31:0], wdata);
    end
  endtask

  task automatic test_decode();
    logic [31:0] addrs [10];
    addrs = '{32'h1000_0010, 32'h1040_0020, 32'h1C00_0000, 32'h1C0F_FFFC, 32'h1A11_0004,
              32'h1A00_0008, 32'h1A11_1000, 32'h1AFF_FFF0, 32'h0000_1000, 32'h1C10_0000};
    for (int k = 0; k < 10; k++)
      access_one(0, k[0], addrs[k], k[1:0]);
  endtask

  task automatic test_write_read();
    for (int rd = 0; rd < 2; rd++) begin
      for (int k = 0; k < 3; k++) begin
        for (int i = 0; i < n_init; i++)
          send(i, rd == 0, slot_addr((i + k) % n_tgt, i, k), next_rand(), k[1:0]);
        step();
      end
      wait_idle();
    end
  endtask

  task automatic test_errors();
    access_one(1, 1'b0, 32'h1030_0000, 2'd1);
    access_one(2, 1'b1, 32'h1080_0000, 2'd2);
    access_one(3, 1'b0, 32'h1B00_0000, 2'd3);
  endtask

  // Second burst lands while the first drains, so a fixed priority would repeat 0
  task automatic test_round_robin();
    logic [73:0] ent;
    apply_reset();
    tlog_q.delete();
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < n_init; i++)
        send(i, 1'b0, slot_addr(tgt_l2, i, b), 32'h0, i[1:0]);
      step();
    end
    wait_idle();
    if (tlog_q.size() != 2 * n_init) begin
      err_cnt++;
      $display("Bursts gave %0d target strobes instead of %0d", tlog_q.size(), 2 * n_init);
    end
    for (int k = 0; k < 2 * n_init && k < tlog_q.size(); k++) begin
      ent = tlog_q[k];
      check_val("tgt_id[3:2]", ent[68:67], k % n_init);  // Grant order follows initiator index
    end
  endtask

  task automatic test_mixed();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] holes [3];
    holes = '{32'h1030_0000, 32'h1080_0000, 32'h1B00_0000};
    for (int c = 0; c < 4; c++) begin
      for (int i = 0; i < n_init; i++) begin
        r = next_rand();
        if (r[31:29] != 3'b000) begin  // Occasionally idle
          if (r[2:0] < 5) addr = slot_addr(r[2:0], i, r[7:4]);
          else            addr = holes[r[2:0] - 5];
          send(i, r[8], addr, next_rand(), r[10:9]);
        end
      end
      step();
    end
    wait_idle();
  endtask

  initial begin
    rst_n      = 1'b0;
    init_req   = '0;
    init_we    = '0;
    init_addr  = '0;
    init_wdata = '0;
    init_id    = '0;
    tgt_rsp    = '0;
    tgt_rdata  = '0;
    tgt_rsp_id = '0;
    pend_req   = '0;
    pend_we    = '0;
    pend_addr  = '0;
    pend_wdata = '0;
    pend_id    = '0;
    chk_cnt    = 0;
    err_cnt    = 0;
    lcg_state  = 32'h1c51_bb86;
    for (int t = 0; t < n_tgt; t++) begin
      for (int w = 0; w < 64; w++) begin
        tmem[t][w]   = {8'hA5, 8'(t), 16'(w * 257)};
        sb_mem[t][w] = tmem[t][w];
      end
    end
    apply_reset();
    test_decode();
    test_write_read();
    test_errors();
    test_round_robin();
    test_mixed();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(test_len * 20 * clk_period);
    $display("Watchdog expired before the tests completed");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: tb.f
src/soc_xbar_pkg.sv
src/bus_req_if.sv
src/req_queue.sv
src/req_router.sv
src/rsp_router.sv
src/soc_xbar.sv
verif/soc_xbar_tb.sv

// File: Bender.yml
package:
  name: soc_xbar

sources:
  - src/soc_xbar_pkg.sv
  - src/bus_req_if.sv
  - src/req_queue.sv
  - src/req_router.sv
  - src/rsp_router.sv
  - src/soc_xbar.sv
  - target: test
    files:
      - verif/soc_xbar_tb.sv
